//--- hw/axis_arb_mux.sv
`default_nettype none
`timescale 1ns/1ns

module axis_arb_mux (
    input  logic                    clk,
    input  logic                    rst_n,

    axis_if.sink                    bypass,
    axis_if.sink                    app,

    output beehive_pkg::axis_data_t m_axis_tx_tdata,
    output beehive_pkg::axis_keep_t m_axis_tx_tkeep,
    output beehive_pkg::axis_user_t m_axis_tx_tuser,
    output logic                    m_axis_tx_tlast,
    output logic                    m_axis_tx_tvalid,
    input  logic                    m_axis_tx_tready
);
    import beehive_pkg::*;

    arb_state_t state_q;
    logic       grant_q;
    logic       last_q;
    logic       sel;
    logic       out_fire;

    // Index 0 is bypass, index 1 is app
    always_comb begin
        if (state_q == ARB_LOCKED) begin
            sel = grant_q;
        end else if (bypass.tvalid && app.tvalid) begin
            sel = ~last_q;
        end else begin
            sel = app.tvalid;
        end
    end

    assign m_axis_tx_tdata  = sel ? app.tdata  : bypass.tdata;
    assign m_axis_tx_tkeep  = sel ? app.tkeep  : bypass.tkeep;
    assign m_axis_tx_tuser  = sel ? app.tuser  : bypass.tuser;
    assign m_axis_tx_tlast  = sel ? app.tlast  : bypass.tlast;
    assign m_axis_tx_tvalid = sel ? app.tvalid : bypass.tvalid;

    // Only the granted input ever sees ready
    assign bypass.tready = ~sel & m_axis_tx_tready;
    assign app.tready    =  sel & m_axis_tx_tready;

    assign out_fire = m_axis_tx_tvalid & m_axis_tx_tready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
            grant_q <= 1'b0;
            // App counts as last served so bypass wins the first tie
            last_q  <= 1'b1;
        end else begin
            if (out_fire) begin
                last_q <= sel;
            end
            case (state_q)
                ARB_IDLE: begin
                    if (out_fire && !m_axis_tx_tlast) begin
                        state_q <= ARB_LOCKED;
                        grant_q <= sel;
                    end
                end
                ARB_LOCKED: begin
                    if (out_fire && m_axis_tx_tlast) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    // ########################################################################
    // Checks
    // ########################################################################

    // A frame in progress keeps its input until its last beat leaves
    property p_grant_held;
        @(posedge clk) disable iff (!rst_n)
        (state_q == ARB_LOCKED && !(out_fire && m_axis_tx_tlast))
            |=> (state_q == ARB_LOCKED && sel == $past(sel));
    endproperty
    a_grant_held: assert property (p_grant_held);

    property p_valid_from_grant;
        @(posedge clk) disable iff (!rst_n)
        m_axis_tx_tvalid |-> (sel ? (app.tvalid && !bypass.tready)
                                  : (bypass.tvalid && !app.tready));
    endproperty
    a_valid_from_grant: assert property (p_valid_from_grant);

endmodule

`default_nettype wire

//--- hw/axis_if.sv
`default_nettype none
`timescale 1ns/1ns

interface axis_if;
    import beehive_pkg::*;

    axis_data_t tdata;
    axis_keep_t tkeep;
    axis_user_t tuser;
    logic       tlast;
    logic       tvalid;
    logic       tready;

    // The source holds tvalid and the payload until tready is seen
    modport source (
        output tdata,
        output tkeep,
        output tuser,
        output tlast,
        output tvalid,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tkeep,
        input  tuser,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

`default_nettype wire

//--- hw/beehive_pkg.sv
`default_nettype none

package beehive_pkg;

    // ########################################################################
    // Stream widths
    // ########################################################################

    localparam int AXIS_DATA_W = 64;
    localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;
    localparam int AXIS_USER_W = 4;

    typedef logic [AXIS_DATA_W-1:0] axis_data_t;
    typedef logic [AXIS_KEEP_W-1:0] axis_keep_t;
    typedef logic [AXIS_USER_W-1:0] axis_user_t;

    // ########################################################################
    // Engine memory port
    // ########################################################################

    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DATA_W = 64;
    localparam int MEM_MASK_W = MEM_DATA_W / 8;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_DATA_W-1:0] mem_data_t;
    typedef logic [MEM_MASK_W-1:0] mem_mask_t;

    // A queued request is never both a read and a write
    typedef struct packed {
        logic      read;
        logic      write;
        mem_addr_t addr;
        mem_data_t writedata;
        mem_mask_t bytemask;
    } mem_req_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

endpackage

`default_nettype wire

//--- hw/beehive_wrapper.sv
`default_nettype none
`timescale 1ns/1ns

module beehive_wrapper #(
    parameter int MEM_QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  beehive_pkg::axis_data_t s_axis_rx_tdata,
    input  beehive_pkg::axis_keep_t s_axis_rx_tkeep,
    input  beehive_pkg::axis_user_t s_axis_rx_tuser,
    input  logic                    s_axis_rx_tlast,
    input  logic                    s_axis_rx_tvalid,
    output logic                    s_axis_rx_tready,

    output beehive_pkg::axis_data_t m_axis_rx_tdata,
    output beehive_pkg::axis_keep_t m_axis_rx_tkeep,
    output beehive_pkg::axis_user_t m_axis_rx_tuser,
    output logic                    m_axis_rx_tlast,
    output logic                    m_axis_rx_tvalid,
    input  logic                    m_axis_rx_tready,

    output beehive_pkg::axis_data_t app_axis_rx_tdata,
    output beehive_pkg::axis_keep_t app_axis_rx_tkeep,
    output beehive_pkg::axis_user_t app_axis_rx_tuser,
    output logic                    app_axis_rx_tlast,
    output logic                    app_axis_rx_tvalid,
    input  logic                    app_axis_rx_tready,

    input  beehive_pkg::axis_data_t s_axis_tx_tdata,
    input  beehive_pkg::axis_keep_t s_axis_tx_tkeep,
    input  beehive_pkg::axis_user_t s_axis_tx_tuser,
    input  logic                    s_axis_tx_tlast,
    input  logic                    s_axis_tx_tvalid,
    output logic                    s_axis_tx_tready,

    input  beehive_pkg::axis_data_t app_axis_tx_tdata,
    input  beehive_pkg::axis_keep_t app_axis_tx_tkeep,
    input  beehive_pkg::axis_user_t app_axis_tx_tuser,
    input  logic                    app_axis_tx_tlast,
    input  logic                    app_axis_tx_tvalid,
    output logic                    app_axis_tx_tready,

    output beehive_pkg::axis_data_t m_axis_tx_tdata,
    output beehive_pkg::axis_keep_t m_axis_tx_tkeep,
    output beehive_pkg::axis_user_t m_axis_tx_tuser,
    output logic                    m_axis_tx_tlast,
    output logic                    m_axis_tx_tvalid,
    input  logic                    m_axis_tx_tready,

    input  logic                    mem_read,
    input  logic                    mem_write,
    input  beehive_pkg::mem_addr_t  mem_address,
    input  beehive_pkg::mem_data_t  mem_writedata,
    input  beehive_pkg::mem_mask_t  mem_byteenable,
    output logic                    mem_ready,
    output beehive_pkg::mem_data_t  mem_readdata,
    output logic                    mem_readdatavalid
);
    import beehive_pkg::*;

    // ########################################################################
    // Receive tap
    // ########################################################################

    logic rx_both_ready;
    logic rx_fire;

    // A beat leaves only when both sinks can take it
    assign rx_both_ready    = m_axis_rx_tready & app_axis_rx_tready;
    assign rx_fire          = s_axis_rx_tvalid & rx_both_ready;
    assign s_axis_rx_tready = rx_both_ready;

    assign m_axis_rx_tdata  = s_axis_rx_tdata;
    assign m_axis_rx_tkeep  = s_axis_rx_tkeep;
    assign m_axis_rx_tuser  = s_axis_rx_tuser;
    assign m_axis_rx_tlast  = s_axis_rx_tlast;
    assign m_axis_rx_tvalid = rx_fire;

    assign app_axis_rx_tdata  = s_axis_rx_tdata;
    assign app_axis_rx_tkeep  = s_axis_rx_tkeep;
    assign app_axis_rx_tuser  = s_axis_rx_tuser;
    assign app_axis_rx_tlast  = s_axis_rx_tlast;
    assign app_axis_rx_tvalid = rx_fire;

    // ########################################################################
    // Transmit merge
    // ########################################################################

    axis_if bypass_tx ();
    axis_if app_tx ();

    assign bypass_tx.tdata  = s_axis_tx_tdata;
    assign bypass_tx.tkeep  = s_axis_tx_tkeep;
    assign bypass_tx.tuser  = s_axis_tx_tuser;
    assign bypass_tx.tlast  = s_axis_tx_tlast;
    assign bypass_tx.tvalid = s_axis_tx_tvalid;
    assign s_axis_tx_tready = bypass_tx.tready;

    assign app_tx.tdata       = app_axis_tx_tdata;
    assign app_tx.tkeep       = app_axis_tx_tkeep;
    assign app_tx.tuser       = app_axis_tx_tuser;
    assign app_tx.tlast       = app_axis_tx_tlast;
    assign app_tx.tvalid      = app_axis_tx_tvalid;
    assign app_axis_tx_tready = app_tx.tready;

    axis_arb_mux u_tx_mux (
        .clk              (clk),
        .rst_n            (rst_n),
        .bypass           (bypass_tx),
        .app              (app_tx),
        .m_axis_tx_tdata  (m_axis_tx_tdata),
        .m_axis_tx_tkeep  (m_axis_tx_tkeep),
        .m_axis_tx_tuser  (m_axis_tx_tuser),
        .m_axis_tx_tlast  (m_axis_tx_tlast),
        .m_axis_tx_tvalid (m_axis_tx_tvalid),
        .m_axis_tx_tready (m_axis_tx_tready)
    );

    // ########################################################################
    // Engine memory bank
    // ########################################################################

    mem_req_t mem_req_enq;
    mem_req_t mem_req_deq;
    logic     mem_req_deq_val;

    assign mem_req_enq.read      = mem_read;
    assign mem_req_enq.write     = mem_write;
    assign mem_req_enq.addr      = mem_address;
    assign mem_req_enq.writedata = mem_writedata;
    assign mem_req_enq.bytemask  = mem_byteenable;

    mem_req_queue #(
        .MEM_QUEUE_DEPTH (MEM_QUEUE_DEPTH)
    ) u_mem_req_q (
        .clk     (clk),
        .rst_n   (rst_n),
        .enq_req (mem_req_enq),
        .enq_val (mem_read | mem_write),
        .enq_rdy (mem_ready),
        .deq_req (mem_req_deq),
        .deq_val (mem_req_deq_val)
    );

    byte_mask_ram u_mem_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (mem_req_deq),
        .req_val (mem_req_deq_val),
        .rd_data (mem_readdata),
        .rd_val  (mem_readdatavalid)
    );

endmodule

`default_nettype wire

//--- hw/byte_mask_ram.sv
`default_nettype none
`timescale 1ns/1ns

module byte_mask_ram (
    input  logic                   clk,
    input  logic                   rst_n,

    input  beehive_pkg::mem_req_t  req,
    input  logic                   req_val,

    output beehive_pkg::mem_data_t rd_data,
    output logic                   rd_val
);
    import beehive_pkg::*;

    localparam int WORDS = 2 ** MEM_ADDR_W;

    mem_data_t words [WORDS];

    // Only the bytes with a set mask bit are written
    always_ff @(posedge clk) begin
        if (req_val && req.write) begin
            for (int b = 0; b < MEM_MASK_W; b++) begin
                if (req.bytemask[b]) begin
                    words[req.addr][b*8 +: 8] <= req.writedata[b*8 +: 8];
                end
            end
        end
        if (req_val && req.read) begin
            rd_data <= words[req.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_val <= 1'b0;
        end else begin
            rd_val <= req_val & req.read;
        end
    end

    // Requests come straight from the memory port through the queue
    property p_one_op;
        @(posedge clk) disable iff (!rst_n)
        req_val |-> !(req.read && req.write);
    endproperty
    a_one_op: assert property (p_one_op);

endmodule

`default_nettype wire

//--- hw/mem_req_queue.sv
`default_nettype none
`timescale 1ns/1ns

module mem_req_queue #(
    parameter int MEM_QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  beehive_pkg::mem_req_t enq_req,
    input  logic                  enq_val,
    output logic                  enq_rdy,

    output beehive_pkg::mem_req_t deq_req,
    output logic                  deq_val
);
    import beehive_pkg::*;

    localparam int PTR_W = (MEM_QUEUE_DEPTH > 1) ? $clog2(MEM_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(MEM_QUEUE_DEPTH + 1);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(MEM_QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MEM_QUEUE_DEPTH - 1);

    mem_req_t         slots [MEM_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             enq_fire;

    assign enq_rdy  = (count_q != FULL_CNT);
    assign enq_fire = enq_val & enq_rdy;

    // The RAM behind the queue never stalls, so the head leaves whenever present
    assign deq_val = (count_q != '0);
    assign deq_req = slots[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            slots[wr_ptr_q] <= enq_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq_val) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({enq_fire, deq_val})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // A full queue has both pointers on the same slot and takes nothing in
    property p_no_enq_when_full;
        @(posedge clk) disable iff (!rst_n)
        (count_q == FULL_CNT) |-> (wr_ptr_q == rd_ptr_q) && !enq_fire;
    endproperty
    a_no_enq_when_full: assert property (p_no_enq_when_full);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_beehive_wrapper \
    --Mdir obj_dir -o tb_beehive_wrapper \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_output=$(./obj_dir/tb_beehive_wrapper)
status=$?
printf '%s\n' "$sim_output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'TEST RESULT: PASS'; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- testbench/tb_beehive_wrapper.sv
`default_nettype none
`timescale 1ns/1ns

module tb_beehive_wrapper;
    import beehive_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int STALL_LIMIT = 50;
    // Rough cycle cost of the six tests in order plus some slack
    localparam int TEST_CYCLES = 20 + 10 + 20 + 80 + 15 + 25;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    axis_data_t s_axis_rx_tdata, m_axis_rx_tdata, app_axis_rx_tdata;
    axis_keep_t s_axis_rx_tkeep, m_axis_rx_tkeep, app_axis_rx_tkeep;
    axis_user_t s_axis_rx_tuser, m_axis_rx_tuser, app_axis_rx_tuser;
    logic       s_axis_rx_tlast, m_axis_rx_tlast, app_axis_rx_tlast;
    logic       s_axis_rx_tvalid, m_axis_rx_tvalid, app_axis_rx_tvalid;
    logic       s_axis_rx_tready, m_axis_rx_tready, app_axis_rx_tready;
    axis_data_t s_axis_tx_tdata, app_axis_tx_tdata, m_axis_tx_tdata;
    axis_keep_t s_axis_tx_tkeep, app_axis_tx_tkeep, m_axis_tx_tkeep;
    axis_user_t s_axis_tx_tuser, app_axis_tx_tuser, m_axis_tx_tuser;
    logic       s_axis_tx_tlast, app_axis_tx_tlast, m_axis_tx_tlast;
    logic       s_axis_tx_tvalid, app_axis_tx_tvalid, m_axis_tx_tvalid;
    logic       s_axis_tx_tready, app_axis_tx_tready, m_axis_tx_tready;
    logic       mem_read, mem_write, mem_ready, mem_readdatavalid;
    mem_addr_t  mem_address;
    mem_data_t  mem_writedata, mem_readdata;
    mem_mask_t  mem_byteenable;

    int         seed = 32'h5218cc06;
    int         value_errors = 0;
    int         other_errors = 0;
    logic       tx_done;
    axis_data_t exp_tdata [$];
    axis_keep_t exp_tkeep [$];
    axis_user_t exp_tuser [$];
    logic       exp_tlast [$];
    mem_data_t  exp_mem [2**MEM_ADDR_W];
    mem_addr_t  rd_addrs [4];

    beehive_wrapper #(.MEM_QUEUE_DEPTH(8)) u_beehive_wrapper (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_axis_data(input string name, input axis_data_t got,
                                   input axis_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_axis_keep(input string name, input axis_keep_t got,
                                   input axis_keep_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_axis_user(input string name, input axis_user_t got,
                                   input axis_user_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_mem_data(input string name, input mem_data_t got, input mem_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // ########################################################################
    // Transmit helpers
    // ########################################################################

    // Beat contents follow from source, frame and beat number alone
    function automatic axis_data_t tx_beat_data(input logic src, input int frame, input int beat);
        return {src ? 16'hA99A : 16'hB00B, 16'(frame), 16'(beat), 16'h5A5A};
    endfunction

    function automatic int tx_frame_len(input logic src, input int frame);
        if (src) begin
            return frame[0] ? 4 : 2;
        end
        return frame[0] ? 2 : 3;
    endfunction

    task automatic expect_frame(input logic src, input int frame);
        int len;
        len = tx_frame_len(src, frame);
        for (int b = 0; b < len; b++) begin
            exp_tdata.push_back(tx_beat_data(src, frame, b));
            exp_tkeep.push_back((b == len - 1) ? 8'h0F : 8'hFF);
            exp_tuser.push_back({src, frame[0], 2'(b)});
            exp_tlast.push_back(b == len - 1);
        end
    endtask

    task automatic drive_tx_stream(input logic src, input int first, input int nframes);
        int         len;
        int         wait_cycles;
        logic       ready;
        axis_keep_t keep;
        axis_user_t user;
        @(posedge clk);
        for (int f = first; f < first + nframes; f++) begin
            len = tx_frame_len(src, f);
            for (int b = 0; b < len; b++) begin
                keep = (b == len - 1) ? 8'h0F : 8'hFF;
                user = {src, f[0], 2'(b)};
                if (src) begin
                    app_axis_tx_tdata  <= tx_beat_data(src, f, b);
                    app_axis_tx_tkeep  <= keep;
                    app_axis_tx_tuser  <= user;
                    app_axis_tx_tlast  <= (b == len - 1);
                    app_axis_tx_tvalid <= 1'b1;
                end else begin
                    s_axis_tx_tdata  <= tx_beat_data(src, f, b);
                    s_axis_tx_tkeep  <= keep;
                    s_axis_tx_tuser  <= user;
                    s_axis_tx_tlast  <= (b == len - 1);
                    s_axis_tx_tvalid <= 1'b1;
                end
                wait_cycles = 0;
                do begin
                    @(negedge clk);
                    ready = src ? app_axis_tx_tready : s_axis_tx_tready;
                    wait_cycles++;
                end while (!ready && wait_cycles < STALL_LIMIT);
                if (!ready) begin
                    $display("ERROR at %0t ns: transmit input %0d was never granted", $time, src);
                    other_errors++;
                end
                @(posedge clk);
            end
        end
        if (src) begin
            app_axis_tx_tvalid <= 1'b0;
        end else begin
            s_axis_tx_tvalid <= 1'b0;
        end
    endtask

    task automatic monitor_tx();
        int   idle;
        logic head_src;
        idle = 0;
        while (exp_tdata.size() > 0 && idle < STALL_LIMIT) begin
            @(negedge clk);
            idle++;
            // Only the input that owns the next expected beat may see ready
            if (m_axis_tx_tvalid) begin
                head_src = exp_tuser[0][3];
                check_bit("s_axis_tx_tready", s_axis_tx_tready,
                          !head_src && m_axis_tx_tready);
                check_bit("app_axis_tx_tready", app_axis_tx_tready,
                          head_src && m_axis_tx_tready);
            end
            if (m_axis_tx_tvalid && m_axis_tx_tready) begin
                check_axis_data("m_axis_tx_tdata", m_axis_tx_tdata, exp_tdata.pop_front());
                check_axis_keep("m_axis_tx_tkeep", m_axis_tx_tkeep, exp_tkeep.pop_front());
                check_axis_user("m_axis_tx_tuser", m_axis_tx_tuser, exp_tuser.pop_front());
                check_bit("m_axis_tx_tlast", m_axis_tx_tlast, exp_tlast.pop_front());
                idle = 0;
            end
        end
        if (exp_tdata.size() > 0) begin
            $display("ERROR at %0t ns: %0d transmit beats never left the output",
                     $time, exp_tdata.size());
            other_errors++;
            exp_tdata.delete();
            exp_tkeep.delete();
            exp_tuser.delete();
            exp_tlast.delete();
        end
        tx_done = 1'b1;
    endtask

    task automatic toggle_tx_ready();
        while (!tx_done) begin
            @(posedge clk);
            m_axis_tx_tready <= 1'($random(seed));
        end
        m_axis_tx_tready <= 1'b1;
    endtask

    task automatic run_tx_frames(input int first, input int n_bypass, input int n_app,
                                 input logic random_ready);
        tx_done = 1'b0;
        fork
            drive_tx_stream(1'b0, first, n_bypass);
            drive_tx_stream(1'b1, first, n_app);
            monitor_tx();
            if (random_ready) toggle_tx_ready();
        join
        @(negedge clk);
        check_bit("m_axis_tx_tvalid", m_axis_tx_tvalid, 1'b0);
    endtask

    // ########################################################################
    // Memory helpers
    // ########################################################################

    task automatic mem_write_word(input mem_addr_t addr, input mem_data_t data,
                                  input mem_mask_t mask);
        int wait_cycles;
        @(posedge clk);
        mem_write      <= 1'b1;
        mem_address    <= addr;
        mem_writedata  <= data;
        mem_byteenable <= mask;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!mem_ready && wait_cycles < STALL_LIMIT);
        if (!mem_ready) begin
            $display("ERROR at %0t ns: memory port never took the write", $time);
            other_errors++;
        end
        @(posedge clk);
        mem_write <= 1'b0;
        for (int b = 0; b < MEM_MASK_W; b++) begin
            if (mask[b]) begin
                exp_mem[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // Read k is accepted on edge k+1, so its data is visible before edge k+3
    task automatic mem_read_burst(input int n);
        for (int c = 0; c < n + 3; c++) begin
            @(posedge clk);
            mem_read <= (c < n);
            if (c < n) begin
                mem_address <= rd_addrs[c];
            end
            @(negedge clk);
            if (c < n) begin
                check_bit("mem_ready", mem_ready, 1'b1);
            end
            check_bit("mem_readdatavalid", mem_readdatavalid, c >= 2 && c - 2 < n);
            if (c >= 2 && c - 2 < n) begin
                check_mem_data("mem_readdata", mem_readdata, exp_mem[rd_addrs[c - 2]]);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // ########################################################################
    // Directed tests
    // ########################################################################

    task automatic test_rx_tap();
        axis_data_t data;
        axis_keep_t keep;
        axis_user_t user;
        for (int i = 0; i < 4; i++) begin
            data = {$random(seed), $random(seed)};
            keep = 8'($random(seed));
            user = 4'($random(seed));
            @(posedge clk);
            s_axis_rx_tdata    <= data;
            s_axis_rx_tkeep    <= keep;
            s_axis_rx_tuser    <= user;
            s_axis_rx_tlast    <= (i == 3);
            s_axis_rx_tvalid   <= 1'b1;
            m_axis_rx_tready   <= i[0];
            app_axis_rx_tready <= ~i[0];
            @(negedge clk);
            check_bit("s_axis_rx_tready", s_axis_rx_tready, 1'b0);
            check_bit("m_axis_rx_tvalid", m_axis_rx_tvalid, 1'b0);
            check_bit("app_axis_rx_tvalid", app_axis_rx_tvalid, 1'b0);
            @(posedge clk);
            m_axis_rx_tready   <= 1'b1;
            app_axis_rx_tready <= 1'b1;
            @(negedge clk);
            check_bit("s_axis_rx_tready", s_axis_rx_tready, 1'b1);
            check_bit("m_axis_rx_tvalid", m_axis_rx_tvalid, 1'b1);
            check_bit("app_axis_rx_tvalid", app_axis_rx_tvalid, 1'b1);
            check_axis_data("m_axis_rx_tdata", m_axis_rx_tdata, data);
            check_axis_data("app_axis_rx_tdata", app_axis_rx_tdata, data);
            check_axis_keep("m_axis_rx_tkeep", m_axis_rx_tkeep, keep);
            check_axis_keep("app_axis_rx_tkeep", app_axis_rx_tkeep, keep);
            check_axis_user("m_axis_rx_tuser", m_axis_rx_tuser, user);
            check_axis_user("app_axis_rx_tuser", app_axis_rx_tuser, user);
            check_bit("m_axis_rx_tlast", m_axis_rx_tlast, i == 3);
            check_bit("app_axis_rx_tlast", app_axis_rx_tlast, i == 3);
        end
        @(posedge clk);
        s_axis_rx_tvalid <= 1'b0;
    endtask

    task automatic test_tx_bypass_only();
        expect_frame(1'b0, 0);
        run_tx_frames(0, 1, 0, 1'b0);
    endtask

    // Bypass takes the first tie after reset, then the sources take turns
    task automatic test_tx_alternation();
        apply_reset();
        expect_frame(1'b0, 2);
        expect_frame(1'b1, 2);
        expect_frame(1'b0, 3);
        expect_frame(1'b1, 3);
        run_tx_frames(2, 2, 2, 1'b0);
    endtask

    task automatic test_tx_backpressure();
        expect_frame(1'b0, 4);
        expect_frame(1'b1, 4);
        expect_frame(1'b0, 5);
        expect_frame(1'b1, 5);
        run_tx_frames(4, 2, 2, 1'b1);
    endtask

    task automatic test_mem_byte_merge();
        mem_addr_t addr;
        addr = 8'($random(seed));
        mem_write_word(addr, {$random(seed), $random(seed)}, 8'hFF);
        mem_write_word(addr, {$random(seed), $random(seed)}, 8'b1010_0101);
        rd_addrs[0] = addr;
        mem_read_burst(1);
    endtask

    task automatic test_mem_read_burst();
        for (int i = 0; i < 4; i++) begin
            rd_addrs[i] = 8'(16 * i + 3);
            mem_write_word(rd_addrs[i], {$random(seed), $random(seed)}, 8'hFF);
        end
        mem_read_burst(4);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t ns: run went past its time budget", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n              <= 1'b0;
        s_axis_rx_tdata    <= '0;
        s_axis_rx_tkeep    <= '0;
        s_axis_rx_tuser    <= '0;
        s_axis_rx_tlast    <= 1'b0;
        s_axis_rx_tvalid   <= 1'b0;
        m_axis_rx_tready   <= 1'b1;
        app_axis_rx_tready <= 1'b1;
        s_axis_tx_tdata    <= '0;
        s_axis_tx_tkeep    <= '0;
        s_axis_tx_tuser    <= '0;
        s_axis_tx_tlast    <= 1'b0;
        s_axis_tx_tvalid   <= 1'b0;
        app_axis_tx_tdata  <= '0;
        app_axis_tx_tkeep  <= '0;
        app_axis_tx_tuser  <= '0;
        app_axis_tx_tlast  <= 1'b0;
        app_axis_tx_tvalid <= 1'b0;
        m_axis_tx_tready   <= 1'b1;
        mem_read           <= 1'b0;
        mem_write          <= 1'b0;
        mem_address        <= '0;
        mem_writedata      <= '0;
        mem_byteenable     <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_rx_tap();
        test_tx_bypass_only();
        test_tx_alternation();
        test_tx_backpressure();
        test_mem_byte_merge();
        test_mem_read_burst();

        repeat (2) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/beehive_pkg.sv
hw/axis_if.sv
hw/axis_arb_mux.sv
hw/mem_req_queue.sv
hw/byte_mask_ram.sv
hw/beehive_wrapper.sv
testbench/tb_beehive_wrapper.sv
